// File: matrix_arb.sv
module matrix_arb import noc_pkg::*; #(
   parameter int size = 4,
   parameter bit multistage = 0,
   parameter bit priority_support = 0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [size-1:0]   request,
   input  flit_priority_t    req_priority [size-1:0],
   input  logic              success,
   output logic [size-1:0]   grant,
   output flit_priority_t    max_priority
);

   // beats[i][j] set when requester i currently wins against requester j
   logic [size-1:0][size-1:0] beats;
   // requesters still in the running after priority filtering
   logic [size-1:0]           eligible;
   logic                      update_en;

   // **********************************************************************
   // priority filter
   // **********************************************************************

   // highest priority among active requests, zero when idle
   always_comb begin
      max_priority = '0;
      for (int i = 0; i < size; i++) begin
         if (request[i] && (req_priority[i] > max_priority)) begin
            max_priority = req_priority[i];
         end
      end
   end

   // without priority support every requester competes
   always_comb begin
      for (int i = 0; i < size; i++) begin
         eligible[i] = request[i] &&
                       (!priority_support || (req_priority[i] == max_priority));
      end
   end

   // **********************************************************************
   // grant
   // **********************************************************************

   // i wins when no eligible requester beats it
   always_comb begin
      for (int i = 0; i < size; i++) begin
         grant[i] = eligible[i];
         for (int k = 0; k < size; k++) begin
            if (eligible[k] && beats[k][i]) begin
               grant[i] = 1'b0;
            end
         end
      end
   end

   // in a multistage allocator the state only moves when the later stage agreed
   assign update_en = (|grant) && (success || !multistage);

   // **********************************************************************
   // priority matrix, upper triangle held in flops
   // **********************************************************************

   for (genvar i = 0; i < size; i++) begin : g_row
      assign beats[i][i] = 1'b0;
      for (genvar j = i + 1; j < size; j++) begin : g_col
         // set: i beats j, reset value gives lower index first
         logic upper;

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               upper <= 1'b1;
            end else if (update_en) begin
               // the winner drops below every other requester
               if (grant[i]) begin
                  upper <= 1'b0;
               end else if (grant[j]) begin
                  upper <= 1'b1;
               end
            end
         end

         // lower triangle is just the complement
         assign beats[i][j] = upper;
         assign beats[j][i] = ~upper;
      end
   end

endmodule

// File: noc_crossbar.sv
module noc_crossbar #(
   parameter int np = 5,
   parameter int nv = 4,
   parameter int flit_width = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [flit_width-1:0] flit_in [np-1:0][nv-1:0],
   input  logic [np-1:0][nv-1:0] vc_mux_sel,
   input  logic [np-1:0][np-1:0] xbar_select,
   output logic [flit_width-1:0] flit_out [np-1:0],
   output logic [np-1:0]         flit_out_valid
);

   // flit of the stage 1 winning vc at each input
   logic [flit_width-1:0] vc_flit [np-1:0];
   // flit steered to each output before the register
   logic [flit_width-1:0] xbar_flit [np-1:0];

   // **********************************************************************
   // vc select, one-hot and-or per input
   // **********************************************************************

   always_comb begin
      for (int i = 0; i < np; i++) begin
         vc_flit[i] = '0;
         for (int v = 0; v < nv; v++) begin
            if (vc_mux_sel[i][v]) begin
               vc_flit[i] = vc_flit[i] | flit_in[i][v];
            end
         end
      end
   end

   // **********************************************************************
   // np x np crossbar, one-hot select per output row
   // **********************************************************************

   always_comb begin
      for (int o = 0; o < np; o++) begin
         xbar_flit[o] = '0;
         for (int i = 0; i < np; i++) begin
            if (xbar_select[o][i]) begin
               xbar_flit[o] = xbar_flit[o] | vc_flit[i];
            end
         end
      end
   end

   // output register, one cycle after the grant
   always_ff @(posedge clk) begin
      for (int o = 0; o < np; o++) begin
         // payload only loads when something was switched here
         if (|xbar_select[o]) begin
            flit_out[o] <= xbar_flit[o];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flit_out_valid <= '0;
      end else begin
         for (int o = 0; o < np; o++) begin
            flit_out_valid[o] <= |xbar_select[o];
         end
      end
   end

endmodule

// File: noc_pkg.sv
package noc_pkg;

   // **********************************************************************
   // router dimensions
   // **********************************************************************

   // ports per router, local plus the four mesh neighbours
   localparam int np = 5;
   // virtual channels per input port
   localparam int nv = 4;
   // flit payload width
   localparam int flit_width = 32;

   // port numbering, local first then clockwise from north
   localparam int port_local = 0;
   localparam int port_north = 1;
   localparam int port_east  = 2;
   localparam int port_south = 3;
   localparam int port_west  = 4;

   // **********************************************************************
   // shared types
   // **********************************************************************

   // one-hot, bit o set means the flit wants output o
   typedef logic [np-1:0] output_port_t;

   // larger value is more urgent
   typedef logic [3:0] flit_priority_t;

   typedef logic [flit_width-1:0] flit_t;

   // **********************************************************************
   // XY routing turn rule
   // **********************************************************************

   // true when dimension-ordered routing can move a flit from in_port to out_port
   function automatic logic route_valid_turn(input int in_port, input int out_port);
      logic valid;
      valid = 1'b1;
      if (in_port == port_local || out_port == port_local) begin
         // injection and ejection are always fine
         valid = 1'b1;
      end else if (in_port == out_port) begin
         // no u-turn back out of the arrival port
         valid = 1'b0;
      end else if ((in_port == port_north || in_port == port_south) &&
                   (out_port == port_east || out_port == port_west)) begin
         // once travelling in y there is no way back into x
         valid = 1'b0;
      end
      return valid;
   endfunction

endpackage

// File: router_switch_checker.sv
module router_switch_checker import noc_pkg::*; #(
   parameter int np = noc_pkg::np,
   parameter int nv = noc_pkg::nv
) (
   input logic                  clk,
   input logic                  rst_n,
   input logic [np-1:0][nv-1:0] req,
   input logic [np-1:0][nv-1:0] grant,
   input logic [np-1:0][np-1:0] xbar_select,
   input logic [np-1:0]         flit_out_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   // number of failed assertions
   int   fail_count = 0;
   logic rows_onehot;
   logic inputs_onehot;

   // each crossbar row and each input's vc grant is one-hot or idle
   always_comb begin
      rows_onehot = 1'b1;
      inputs_onehot = 1'b1;
      for (int o = 0; o < np; o++) begin
         rows_onehot = rows_onehot & $onehot0(xbar_select[o]);
      end
      for (int i = 0; i < np; i++) begin
         inputs_onehot = inputs_onehot & $onehot0(grant[i]);
      end
   end

   a_xbar_row: assert property (@(posedge clk) disable iff (!rst_n) rows_onehot)
      else begin
         $error("an xbar_select row names more than one input");
         fail_count++;
      end

   a_one_vc: assert property (@(posedge clk) disable iff (!rst_n) inputs_onehot)
      else begin
         $error("an input port was granted more than one vc");
         fail_count++;
      end

   // a vc never gets a grant it did not ask for
   a_grant_req: assert property (@(posedge clk) disable iff (!rst_n) (grant & ~req) == '0)
      else begin
         $error("grant raised for a vc with no request");
         fail_count++;
      end

   // the crossbar output register comes out of reset empty
   a_reset_clear: assert property (@(posedge clk) $rose(rst_n) |-> flit_out_valid == '0)
      else begin
         $error("flit_out_valid not clear after reset");
         fail_count++;
      end

endmodule

// the top level sees both the allocator selects and the crossbar valids
bind router_switch_top router_switch_checker #(.np(np), .nv(nv)) u_checker (
   .clk            (clk),
   .rst_n          (rst_n),
   .req            (req),
   .grant          (grant),
   .xbar_select    (xbar_select),
   .flit_out_valid (flit_out_valid)
);

// File: router_switch_monitor.sv
module router_switch_monitor import noc_pkg::*; #(
   parameter bit dynamic_priority_switch_alloc = 0,
   parameter bit turn_opt = 1
) (
   input logic                  clk,
   input logic                  rst_n,
   input logic [np-1:0][nv-1:0] req,
   input flit_priority_t        req_priority [np-1:0][nv-1:0],
   input output_port_t          output_port [np-1:0][nv-1:0],
   input flit_t                 flit_in [np-1:0][nv-1:0],
   input logic [np-1:0][nv-1:0] grant,
   input logic [np-1:0]         any_request_for_output,
   input flit_t                 flit_out [np-1:0],
   input logic [np-1:0]         flit_out_valid,
   // directed grant from the stimulus table
   input logic [np-1:0][nv-1:0] table_grant,
   input logic                  table_check
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef int rank_q_t [$];

   int            error_count = 0;
   // arbitration order per arbiter, front of the queue wins first
   rank_q_t       in_order [np];
   rank_q_t       out_order [np];
   // model of the crossbar output register
   logic [np-1:0] exp_valid = '0;
   flit_t         exp_flit [np];

   // XY routing, bit o set when output o is reachable from in_port
   function automatic logic [4:0] legal_outputs(int in_port);
      case (in_port)
         port_north: return 5'b01001;
         port_south: return 5'b00011;
         port_east:  return 5'b11011;
         port_west:  return 5'b01111;
         default:    return 5'b11111;
      endcase
   endfunction

   // least recently granted, the winner goes to the back
   function automatic rank_q_t demote(rank_q_t order, int winner);
      rank_q_t result;
      foreach (order[k]) begin
         if (order[k] != winner) result.push_back(order[k]);
      end
      result.push_back(winner);
      return result;
   endfunction

   task automatic reset_order();
      for (int a = 0; a < np; a++) begin
         in_order[a] = {};
         out_order[a] = {};
         for (int k = 0; k < nv; k++) in_order[a].push_back(k);
         for (int k = 0; k < np; k++) out_order[a].push_back(k);
      end
   endtask

   task automatic compare(string name, logic [63:0] expected, logic [63:0] actual);
      if (actual !== expected) begin
         error_count++;
         $display("Mismatch %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
      end
   endtask

   initial reset_order();

   // **********************************************************************
   // predict at the falling edge, inputs and grants are settled there
   // **********************************************************************

   always @(negedge clk) begin
      int                    win_vc [np];
      int                    win_in [np];
      flit_priority_t        top_vc [np];
      flit_priority_t        top_in;
      logic [4:0]            legal;
      logic [np-1:0][np-1:0] bid;
      logic [np-1:0][nv-1:0] exp_grant;
      logic [np-1:0]         exp_any;
      bid = '0;
      exp_grant = '0;
      // stage 1, highest priority then oldest vc per input
      for (int i = 0; i < np; i++) begin
         top_vc[i] = '0;
         win_vc[i] = -1;
         for (int v = 0; v < nv; v++) begin
            if (req[i][v] && req_priority[i][v] > top_vc[i]) top_vc[i] = req_priority[i][v];
         end
         for (int k = 0; k < in_order[i].size(); k++) begin
            if (win_vc[i] < 0 && req[i][in_order[i][k]] && (!dynamic_priority_switch_alloc ||
                req_priority[i][in_order[i][k]] == top_vc[i])) win_vc[i] = in_order[i][k];
         end
         legal = turn_opt ? legal_outputs(i) : 5'b11111;
         if (win_vc[i] >= 0) begin
            for (int o = 0; o < np; o++) bid[o][i] = output_port[i][win_vc[i]][o] && legal[o];
         end
      end
      // stage 2, same rule across inputs at each output
      for (int o = 0; o < np; o++) begin
         top_in = '0;
         win_in[o] = -1;
         for (int i = 0; i < np; i++) begin
            if (bid[o][i] && top_vc[i] > top_in) top_in = top_vc[i];
         end
         for (int k = 0; k < out_order[o].size(); k++) begin
            if (win_in[o] < 0 && bid[o][out_order[o][k]] && (!dynamic_priority_switch_alloc ||
                top_vc[out_order[o][k]] == top_in)) win_in[o] = out_order[o][k];
         end
         exp_any[o] = |bid[o];
         if (win_in[o] >= 0) exp_grant[win_in[o]][win_vc[win_in[o]]] = 1'b1;
      end
      compare("grant", exp_grant, grant);
      compare("any_request_for_output", exp_any, any_request_for_output);
      compare("flit_out_valid", exp_valid, flit_out_valid);
      for (int o = 0; o < np; o++) begin
         if (exp_valid[o]) compare($sformatf("flit_out[%0d]", o), exp_flit[o], flit_out[o]);
      end
      if (table_check) compare("grant vs table", table_grant, grant);
      // state seen after the coming rising edge
      if (!rst_n) begin
         reset_order();
         exp_valid = '0;
      end else begin
         for (int o = 0; o < np; o++) begin
            exp_valid[o] = win_in[o] >= 0;
            if (win_in[o] >= 0) begin
               exp_flit[o] = flit_in[win_in[o]][win_vc[win_in[o]]];
               out_order[o] = demote(out_order[o], win_in[o]);
            end
         end
         for (int i = 0; i < np; i++) begin
            if (|exp_grant[i]) in_order[i] = demote(in_order[i], win_vc[i]);
         end
      end
   end

endmodule

// File: router_switch_tb.sv
module router_switch_tb import noc_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_steps = 8;
   localparam int max_hold = 4;
   localparam int random_cycles = 200;

   logic                  clk;
   logic                  rst_n;
   logic [np-1:0][nv-1:0] req;
   flit_priority_t        req_priority [np-1:0][nv-1:0];
   output_port_t          output_port [np-1:0][nv-1:0];
   flit_t                 flit_in [np-1:0][nv-1:0];
   logic [np-1:0][nv-1:0] grant;
   logic [np-1:0]         any_request_for_output;
   flit_t                 flit_out [np-1:0];
   logic [np-1:0]         flit_out_valid;
   logic [np-1:0][nv-1:0] table_grant;
   logic                  table_check;
   int                    seed = 32'h8b54_7be7;
   int                    flit_tag = 0;

   // **********************************************************************
   // stimulus table
   // **********************************************************************

   // request code {input, vc, output, priority} per slot
   // input f marks an empty slot
   logic [15:0] step_req [n_steps][3] = '{
      '{16'hffff, 16'hffff, 16'hffff},  // idle
      '{16'h0021, 16'hffff, 16'hffff},  // lone local to east
      '{16'h1000, 16'h2000, 16'hffff},  // two inputs fight for local
      '{16'h3110, 16'h3210, 16'hffff},  // two vcs of south fight for north
      '{16'h1120, 16'h2320, 16'h4030},  // north to east and a u-turn next to a legal move
      '{16'h0142, 16'h2249, 16'hffff},  // higher priority input wins west
      '{16'h4017, 16'h4317, 16'h4112},  // two urgent vcs share while the low one waits
      '{16'hffff, 16'hffff, 16'hffff}   // drain
   };
   int          step_hold [n_steps] = '{2, 2, 4, 4, 3, 2, 3, 2};
   // grant expected in the first cycle of each step
   // hex digit i holds the vcs of input i
   logic [19:0] step_grant [n_steps] = '{20'h00000, 20'h00001, 20'h00010, 20'h02000,
                                         20'h10000, 20'h00400, 20'h80000, 20'h00000};

   router_switch_top #(
      .dynamic_priority_switch_alloc (1),
      .turn_opt                      (1)
   ) u_router_switch_top (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .req                    (req),
      .req_priority           (req_priority),
      .output_port            (output_port),
      .flit_in                (flit_in),
      .grant                  (grant),
      .any_request_for_output (any_request_for_output),
      .flit_out               (flit_out),
      .flit_out_valid         (flit_out_valid)
   );

   // reference model and comparison against the DUT
   router_switch_monitor #(
      .dynamic_priority_switch_alloc (1),
      .turn_opt                      (1)
   ) u_monitor (.*);

   always #50 clk = ~clk;

   // flits carry input, vc and a running tag so each one is unique
   task automatic load_flits();
      for (int i = 0; i < np; i++) begin
         for (int v = 0; v < nv; v++) flit_in[i][v] = {4'(i), 4'(v), 24'(flit_tag)};
      end
      flit_tag++;
   endtask

   task automatic clear_inputs();
      req = '0;
      for (int i = 0; i < np; i++) begin
         for (int v = 0; v < nv; v++) begin
            req_priority[i][v] = '0;
            output_port[i][v] = '0;
         end
      end
      load_flits();
   endtask

   task automatic apply_step(int s);
      logic [15:0] code;
      clear_inputs();
      for (int e = 0; e < 3; e++) begin
         code = step_req[s][e];
         if (code[15:12] != 4'hf) begin
            req[code[15:12]][code[11:8]] = 1'b1;
            output_port[code[15:12]][code[11:8]] = output_port_t'(1) << code[7:4];
            req_priority[code[15:12]][code[11:8]] = code[3:0];
         end
      end
   endtask

   task automatic apply_random();
      for (int i = 0; i < np; i++) begin
         for (int v = 0; v < nv; v++) begin
            req[i][v] = 1'($random(seed));
            output_port[i][v] = output_port_t'(1) << ({$random(seed)} % np);
            req_priority[i][v] = flit_priority_t'($random(seed) & 3);
         end
      end
      load_flits();
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      table_grant = '0;
      table_check = 1'b0;
      // two inputs already bid for local while reset is held
      apply_step(2);
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      // each table row is held for its count
      // the grant is checked on the first cycle of the row
      for (int s = 0; s < n_steps; s++) begin
         for (int h = 0; h < step_hold[s]; h++) begin
            apply_step(s);
            table_grant = step_grant[s];
            table_check = (h == 0);
            @(posedge clk);
            #1;
         end
      end
      table_check = 1'b0;
      for (int c = 0; c < random_cycles; c++) begin
         apply_random();
         @(posedge clk);
         #1;
      end
      clear_inputs();
      repeat (3) @(posedge clk);
      $display("summary: %0d mismatches, %0d assertion failures", u_monitor.error_count,
               u_router_switch_top.u_checker.fail_count);
      if (u_monitor.error_count == 0 && u_router_switch_top.u_checker.fail_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // watchdog sized for the table and random phases plus margin for reset and drain
   initial begin
      #((n_steps * max_hold + random_cycles + 20) * 100);
      $display("timeout: the run did not reach its end in the expected number of cycles");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: router_switch_top.sv
module router_switch_top import noc_pkg::*; #(
   parameter int np = noc_pkg::np,
   parameter int nv = noc_pkg::nv,
   parameter int flit_width = noc_pkg::flit_width,
   parameter bit dynamic_priority_switch_alloc = 0,
   parameter bit turn_opt = 1
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // from the vc buffers
   input  logic [np-1:0][nv-1:0] req,
   input  flit_priority_t        req_priority [np-1:0][nv-1:0],
   input  output_port_t          output_port [np-1:0][nv-1:0],
   input  flit_t                 flit_in [np-1:0][nv-1:0],
   // back to the vc buffers, same cycle as the request
   output logic [np-1:0][nv-1:0] grant,
   output logic [np-1:0]         any_request_for_output,
   // switched flits, one cycle after the grant
   output flit_t                 flit_out [np-1:0],
   output logic [np-1:0]         flit_out_valid
);

   // **********************************************************************
   // allocator to crossbar selects
   // **********************************************************************

   logic [np-1:0][nv-1:0] vc_mux_sel;
   logic [np-1:0][np-1:0] xbar_select;

   // separable input-first switch allocation
   vc_switch_allocator #(
      .np                            (np),
      .nv                            (nv),
      .dynamic_priority_switch_alloc (dynamic_priority_switch_alloc),
      .turn_opt                      (turn_opt)
   ) u_alloc (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .req                    (req),
      .req_priority           (req_priority),
      .output_port            (output_port),
      .grant                  (grant),
      .vc_mux_sel             (vc_mux_sel),
      .xbar_select            (xbar_select),
      .any_request_for_output (any_request_for_output)
   );

   // registered crossbar
   noc_crossbar #(
      .np         (np),
      .nv         (nv),
      .flit_width (flit_width)
   ) u_xbar (
      .clk            (clk),
      .rst_n          (rst_n),
      .flit_in        (flit_in),
      .vc_mux_sel     (vc_mux_sel),
      .xbar_select    (xbar_select),
      .flit_out       (flit_out),
      .flit_out_valid (flit_out_valid)
   );

endmodule

// File: sources.f
noc_pkg.sv
matrix_arb.sv
vc_switch_allocator.sv
noc_crossbar.sv
router_switch_top.sv
router_switch_checker.sv
router_switch_monitor.sv
router_switch_tb.sv

// File: vc_switch_allocator.sv
module vc_switch_allocator import noc_pkg::*; #(
   parameter int np = noc_pkg::np,
   parameter int nv = noc_pkg::nv,
   parameter bit dynamic_priority_switch_alloc = 0,
   parameter bit turn_opt = 1
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [np-1:0][nv-1:0] req,
   input  flit_priority_t        req_priority [np-1:0][nv-1:0],
   input  output_port_t          output_port [np-1:0][nv-1:0],
   output logic [np-1:0][nv-1:0] grant,
   output logic [np-1:0][nv-1:0] vc_mux_sel,
   output logic [np-1:0][np-1:0] xbar_select,
   output logic [np-1:0]         any_request_for_output
);

   // stage 1 winner per input, one-hot over the vcs
   logic [np-1:0][nv-1:0] stage1_grant;
   // input won at some output in stage 2
   logic [np-1:0]         input_port_success;
   // priority of the stage 1 winner, carried into stage 2
   flit_priority_t        max_priority [np-1:0];
   // output port wanted by the stage 1 winner
   output_port_t          winning_port_req [np-1:0];
   // stage 2 requests and grants, indexed [output][input]
   logic [np-1:0][np-1:0] output_port_req;
   logic [np-1:0][np-1:0] output_port_grant;
   flit_priority_t        req_priority_stage2 [np-1:0][np-1:0];

   // crossbar takes the stage 1 pick as its vc select
   assign vc_mux_sel = stage1_grant;

   // one-hot select of the winning vc's output port request
   always_comb begin
      for (int i = 0; i < np; i++) begin
         winning_port_req[i] = '0;
         for (int v = 0; v < nv; v++) begin
            if (stage1_grant[i][v]) begin
               winning_port_req[i] = winning_port_req[i] | output_port[i][v];
            end
         end
      end
   end

   for (genvar i = 0; i < np; i++) begin : g_inport

      // **********************************************************************
      // nv:1 arbiter at each input port
      // **********************************************************************

      // multistage so that losing in stage 2 keeps the vc order unchanged
      matrix_arb #(
         .size             (nv),
         .multistage       (1),
         .priority_support (dynamic_priority_switch_alloc)
      ) u_vc_arb (
         .clk          (clk),
         .rst_n        (rst_n),
         .request      (req[i]),
         .req_priority (req_priority[i]),
         .success      (input_port_success[i]),
         .grant        (stage1_grant[i]),
         .max_priority (max_priority[i])
      );

      // transpose into per-output request rows
      for (genvar o = 0; o < np; o++) begin : g_route
         // forbidden turns never reach the output arbiter
         assign output_port_req[o][i] = winning_port_req[i][o] &&
                                        (!turn_opt || route_valid_turn(i, o));
         // an input bids at stage 2 with its winner's priority
         assign req_priority_stage2[o][i] = max_priority[i];
      end

      // a vc is granted only when its input also won an output
      assign grant[i] = stage1_grant[i] & {nv{input_port_success[i]}};
   end

   for (genvar o = 0; o < np; o++) begin : g_outport

      // **********************************************************************
      // np:1 arbiter at each output port
      // **********************************************************************

      // single stage, success is tied off and ignored
      matrix_arb #(
         .size             (np),
         .multistage       (0),
         .priority_support (dynamic_priority_switch_alloc)
      ) u_outport_arb (
         .clk          (clk),
         .rst_n        (rst_n),
         .request      (output_port_req[o]),
         .req_priority (req_priority_stage2[o]),
         .success      (1'b1),
         .grant        (output_port_grant[o]),
         .max_priority ()
      );

      assign any_request_for_output[o] = |output_port_req[o];
   end

   // OR the stage 2 grants seen by each input
   always_comb begin
      for (int i = 0; i < np; i++) begin
         input_port_success[i] = 1'b0;
         for (int o = 0; o < np; o++) begin
            input_port_success[i] = input_port_success[i] | output_port_grant[o][i];
         end
      end
   end

   // row o names the input that drives output o
   assign xbar_select = output_port_grant;

endmodule
